// File: compile.f
+incdir+source
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
verification/uart_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the UART testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module uart_top_tb \
  -f compile.f -o uart_sim \
  && ./obj_dir/uart_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error status"

cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"

// File: source/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_baud_gen (
  input  logic sys_clk,
  input  logic sys_rst_l,
  output logic baud_tick
);

  localparam int unsigned DIV   = `UART_CLK_DIV;
  localparam int unsigned CNT_W = ($clog2(DIV) > 0) ? $clog2(DIV) : 1;

  logic [CNT_W-1:0] div_cnt;

  // free running divider, the tick fires once per wrap
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      div_cnt   <= '0;
      baud_tick <= 1'b0;
    end else if (div_cnt == CNT_W'(DIV - 1)) begin
      div_cnt   <= '0;
      baud_tick <= 1'b1;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      baud_tick <= 1'b0;
    end
  end

endmodule

// File: source/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// sys_clk cycles per oversampling tick
// the small default keeps a bit time at 64 clocks
`define UART_CLK_DIV 4

// ticks per bit cell on both the receive and transmit side
`define UART_OVERSAMPLE 16

// data bits per frame, sent least significant bit first
`define UART_WORD_LEN 8

`endif

// File: source/uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

  // one data word as it appears on the parallel side
  typedef logic [`UART_WORD_LEN-1:0] uart_byte_t;

  // position inside one bit cell, counted in oversampling ticks
  typedef logic [3:0] tick_cnt_t;

  // number of data bits already handled within a frame
  typedef logic [3:0] bit_cnt_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic                 baud_tick,
  input  logic                 uart_rxd,
  output uart_pkg::uart_byte_t rx_data,
  output logic                 rx_valid,
  output logic                 rx_frame_error
);

  import uart_pkg::*;

  // the start bit is checked half a bit after the falling edge was seen
  localparam tick_cnt_t MID_TICK  = tick_cnt_t'(`UART_OVERSAMPLE / 2 - 1);
  localparam tick_cnt_t LAST_TICK = tick_cnt_t'(`UART_OVERSAMPLE - 1);
  localparam bit_cnt_t  LAST_BIT  = bit_cnt_t'(`UART_WORD_LEN - 1);

  logic       rxd_meta;
  logic       rxd_sync;
  rx_state_t  state;
  tick_cnt_t  tick_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t shift_reg;
  logic       cell_end;

  // two flop synchronizer, reset to the idle line level so reset
  // never looks like a start bit
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // a full bit cell after the start centre lands on the next bit centre
  assign cell_end = baud_tick && (tick_cnt == LAST_TICK);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (baud_tick) begin
      tick_cnt <= tick_cnt + 1'b1;
      unique case (state)
        RX_IDLE: begin
          // hold the counter so the start check is timed from the edge
          tick_cnt <= '0;
          if (!rxd_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (tick_cnt == MID_TICK) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            // a high line here was only a glitch
            if (rxd_sync) begin
              state <= RX_IDLE;
            end else begin
              state <= RX_DATA;
            end
          end
        end
        RX_DATA: begin
          if (tick_cnt == LAST_TICK) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (tick_cnt == LAST_TICK) begin
            state <= RX_IDLE;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // data arrives lsb first, so each new bit enters at the top
  always_ff @(posedge sys_clk) begin
    if (cell_end && (state == RX_DATA)) begin
      shift_reg <= {rxd_sync, shift_reg[`UART_WORD_LEN-1:1]};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_data        <= '0;
      rx_valid       <= 1'b0;
      rx_frame_error <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (cell_end && (state == RX_STOP)) begin
        rx_data        <= shift_reg;
        // the stop bit must be high, anything else is a framing fault
        rx_frame_error <= !rxd_sync;
        rx_valid       <= 1'b1;
      end
    end
  end

endmodule

// File: source/uart_top.sv
`timescale 1ns/1ps

module uart_top (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic                 tx_valid,
  input  logic                 uart_rxd,
  input  uart_pkg::uart_byte_t tx_data,
  output logic                 tx_ready,
  output logic                 uart_txd,
  output logic                 rx_valid,
  output logic                 rx_frame_error,
  output uart_pkg::uart_byte_t rx_data
);

  // one tick shared by both directions keeps their bit rates identical
  logic baud_tick;

  uart_baud_gen u_baud_gen (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick)
  );

  uart_rx u_rx (
    .sys_clk        (sys_clk),
    .sys_rst_l      (sys_rst_l),
    .baud_tick      (baud_tick),
    .uart_rxd       (uart_rxd),
    .rx_data        (rx_data),
    .rx_valid       (rx_valid),
    .rx_frame_error (rx_frame_error)
  );

  uart_tx u_tx (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready),
    .uart_txd  (uart_txd)
  );

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic                 baud_tick,
  input  logic                 tx_valid,
  input  uart_pkg::uart_byte_t tx_data,
  output logic                 tx_ready,
  output logic                 uart_txd
);

  import uart_pkg::*;

  localparam tick_cnt_t LAST_TICK = tick_cnt_t'(`UART_OVERSAMPLE - 1);
  localparam bit_cnt_t  LAST_BIT  = bit_cnt_t'(`UART_WORD_LEN - 1);

  tx_state_t  state;
  tick_cnt_t  tick_cnt;
  bit_cnt_t   bit_cnt;
  uart_byte_t shift_reg;
  logic       accept;
  logic       bit_end;

  assign accept  = tx_valid && tx_ready;
  assign bit_end = baud_tick && (tick_cnt == LAST_TICK);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      tx_ready <= 1'b1;
      uart_txd <= 1'b1;
    end else begin
      unique case (state)
        TX_IDLE: begin
          if (accept) begin
            tx_ready <= 1'b0;
          end else if (!tx_ready && baud_tick) begin
            // a byte is waiting, open the frame on this tick
            state    <= TX_START;
            tick_cnt <= '0;
            uart_txd <= 1'b0;
          end
        end
        TX_START: begin
          if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (bit_end) begin
            state    <= TX_DATA;
            bit_cnt  <= '0;
            uart_txd <= shift_reg[0];
          end
        end
        TX_DATA: begin
          if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state    <= TX_STOP;
              uart_txd <= 1'b1;
            end else begin
              uart_txd <= shift_reg[0];
            end
          end
        end
        TX_STOP: begin
          if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (bit_end) begin
            state    <= TX_IDLE;
            tx_ready <= 1'b1;
          end
        end
        default: begin
          state    <= TX_IDLE;
          tx_ready <= 1'b1;
          uart_txd <= 1'b1;
        end
      endcase
    end
  end

  // bit 0 is always the next one to send, the register drains downward
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      shift_reg <= tx_data;
    end else if (bit_end && ((state == TX_START) || (state == TX_DATA))) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

// File: verification/uart_top_tb.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_top_tb;

  import uart_pkg::*;

  localparam int BIT_CLKS  = `UART_CLK_DIV * `UART_OVERSAMPLE;
  localparam int HALF_CLKS = BIT_CLKS / 2;
  localparam int NUM_CASES = 12;

  localparam logic [1:0] MODE_LOOP   = 2'd0;
  localparam logic [1:0] MODE_FRAME  = 2'd1;
  localparam logic [1:0] MODE_GLITCH = 2'd2;

  typedef struct packed {
    uart_byte_t data;
    logic       fe;
    logic [1:0] mode;
    logic       hold;
  } case_t;

  logic       sys_clk;
  logic       sys_rst_l;
  logic       tx_valid;
  uart_byte_t tx_data;
  logic       tx_ready;
  logic       uart_txd;
  logic       uart_rxd;
  logic       rx_valid;
  logic       rx_frame_error;
  uart_byte_t rx_data;
  logic       loopback;
  logic       inj_line;

  case_t      cases [NUM_CASES];
  uart_byte_t rx_data_q [$];
  logic       rx_fe_q [$];

  // the receiver listens either to the transmitter or to the bit-banged line
  assign uart_rxd = loopback ? uart_txd : inj_line;

  uart_top uut (
    .sys_clk        (sys_clk),
    .sys_rst_l      (sys_rst_l),
    .tx_valid       (tx_valid),
    .uart_rxd       (uart_rxd),
    .tx_data        (tx_data),
    .tx_ready       (tx_ready),
    .uart_txd       (uart_txd),
    .rx_valid       (rx_valid),
    .rx_frame_error (rx_frame_error),
    .rx_data        (rx_data)
  );

  initial begin
    sys_clk = 1'b0;
    forever begin
      #10 sys_clk = ~sys_clk;
    end
  end

  // every receive pulse is recorded, so a stray second pulse is seen later
  always @(posedge sys_clk) begin
    if (sys_rst_l && rx_valid) begin
      rx_data_q.push_back(rx_data);
      rx_fe_q.push_back(rx_frame_error);
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else abort_run($sformatf("Error: %s expected 0x%0h got 0x%0h",
                                                  name, exp, got));
  endtask

  task automatic compare_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
    assert (got === exp) else abort_run($sformatf("Error: %s expected 0x%02h got 0x%02h",
                                                  name, exp, got));
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge sys_clk);
  endtask

  function automatic case_t make_case(input uart_byte_t data, input logic fe,
                                      input logic [1:0] mode, input logic hold);
    return {data, fe, mode, hold};
  endfunction

  // a held entry must be followed by a loopback entry, which becomes the waiting byte
  task automatic build_cases();
    cases[0]  = make_case(8'h00, 1'b0, MODE_LOOP, 1'b0);
    cases[1]  = make_case(8'hFF, 1'b0, MODE_LOOP, 1'b0);
    cases[2]  = make_case(8'h55, 1'b0, MODE_LOOP, 1'b1);
    cases[3]  = make_case(8'hA5, 1'b0, MODE_LOOP, 1'b0);
    cases[4]  = make_case(uart_byte_t'($urandom), 1'b0, MODE_LOOP, 1'b1);
    cases[5]  = make_case(uart_byte_t'($urandom), 1'b0, MODE_LOOP, 1'b0);
    cases[6]  = make_case(8'h00, 1'b0, MODE_GLITCH, 1'b0);
    cases[7]  = make_case(8'h3C, 1'b1, MODE_FRAME, 1'b0);
    cases[8]  = make_case(uart_byte_t'($urandom), 1'b0, MODE_FRAME, 1'b0);
    cases[9]  = make_case(uart_byte_t'($urandom), 1'b0, MODE_LOOP, 1'b0);
    cases[10] = make_case(uart_byte_t'($urandom), 1'b0, MODE_LOOP, 1'b1);
    cases[11] = make_case(uart_byte_t'($urandom), 1'b0, MODE_LOOP, 1'b0);
  endtask

  task automatic send_byte(input uart_byte_t data, input logic hold, input uart_byte_t next_data);
    int cnt;
    cnt = 0;
    tx_data  = data;
    tx_valid = 1'b1;
    while (!tx_ready) begin
      @(negedge sys_clk);
      cnt++;
      assert (cnt < 12 * BIT_CLKS) else abort_run("tx_ready did not return high in time");
    end
    // ready is high now, so the next rising edge takes the byte
    @(negedge sys_clk);
    compare_bit("tx_ready", 1'b0, tx_ready);
    if (hold) begin
      tx_data = next_data;
    end else begin
      tx_valid = 1'b0;
    end
  endtask

  task automatic sample_tx_frame(input uart_byte_t data);
    int                        cnt;
    logic [`UART_WORD_LEN+1:0] frame;
    cnt   = 0;
    frame = {1'b1, data, 1'b0};
    while (uart_txd) begin
      @(negedge sys_clk);
      cnt++;
      assert (cnt < 2 * BIT_CLKS) else abort_run("no start bit appeared on uart_txd");
    end
    // the edge came half a clock ago and the start bit centre lies half a bit after it
    wait_clocks(HALF_CLKS - 1);
    for (int i = 0; i < `UART_WORD_LEN + 2; i++) begin
      compare_bit($sformatf("uart_txd bit %0d", i), frame[0], uart_txd);
      compare_bit("tx_ready", 1'b0, tx_ready);
      frame = frame >> 1;
      if (i < `UART_WORD_LEN + 1) begin
        wait_clocks(BIT_CLKS);
      end
    end
  endtask

  task automatic expect_rx(input uart_byte_t data, input logic fe);
    int         cnt;
    uart_byte_t got_data;
    logic       got_fe;
    cnt = 0;
    while (rx_data_q.size() == 0) begin
      @(negedge sys_clk);
      cnt++;
      assert (cnt < 2 * BIT_CLKS) else abort_run("rx_valid did not pulse for a sent frame");
    end
    got_data = rx_data_q.pop_front();
    got_fe   = rx_fe_q.pop_front();
    compare_byte("rx_data", data, got_data);
    compare_bit("rx_frame_error", fe, got_fe);
    assert (rx_data_q.size() == 0) else abort_run("rx_valid pulsed more than once for a frame");
  endtask

  task automatic drive_frame(input uart_byte_t data, input logic stop_bit);
    logic [`UART_WORD_LEN+1:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < `UART_WORD_LEN + 2; i++) begin
      inj_line = frame[0];
      frame    = frame >> 1;
      wait_clocks(BIT_CLKS);
    end
    inj_line = 1'b1;
  endtask

  task automatic drive_glitch();
    inj_line = 1'b0;
    wait_clocks(3 * `UART_CLK_DIV);
    inj_line = 1'b1;
    // a rejected start must stay silent for twelve bit times
    for (int i = 0; i < 12 * BIT_CLKS; i++) begin
      @(negedge sys_clk);
      assert (rx_data_q.size() == 0) else abort_run("rx_valid pulsed after a start glitch");
    end
  endtask

  initial begin
    void'($urandom(38311));
    sys_rst_l = 1'b0;
    tx_valid  = 1'b0;
    tx_data   = '0;
    loopback  = 1'b1;
    inj_line  = 1'b1;
    build_cases();

    repeat (10) @(negedge sys_clk);
    sys_rst_l = 1'b1;
    compare_bit("uart_txd", 1'b1, uart_txd);
    compare_bit("tx_ready", 1'b1, tx_ready);
    compare_bit("rx_valid", 1'b0, rx_valid);
    compare_bit("rx_frame_error", 1'b0, rx_frame_error);
    compare_byte("rx_data", 8'h00, rx_data);

    for (int i = 0; i < NUM_CASES; i++) begin
      assert (rx_data_q.size() == 0) else abort_run("rx_valid pulsed outside of a frame");
      case (cases[i].mode)
        MODE_LOOP: begin
          loopback = 1'b1;
          send_byte(cases[i].data, cases[i].hold, cases[(i + 1) % NUM_CASES].data);
          sample_tx_frame(cases[i].data);
          expect_rx(cases[i].data, cases[i].fe);
        end
        MODE_FRAME: begin
          loopback = 1'b0;
          drive_frame(cases[i].data, !cases[i].fe);
          expect_rx(cases[i].data, cases[i].fe);
          wait_clocks(BIT_CLKS);
        end
        default: begin
          loopback = 1'b0;
          drive_glitch();
        end
      endcase
    end

    // the last frame gets no following case, so a second pulse for it shows up only here
    wait_clocks(2 * BIT_CLKS);
    assert (rx_data_q.size() == 0) else abort_run("rx_valid pulsed again after the last frame");

    $display("RESULT: PASS");
    $finish;
  end

endmodule
